// ==== verilog/mipsDefines.svh ====
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// primary opcodes, instr[31:26]
`define OP_RTYPE 6'h00
`define OP_ORI   6'h0d
`define OP_LUI   6'h0f
`define OP_LW    6'h23
`define OP_SW    6'h2b
`define OP_BEQ   6'h04

// r-type function field, instr[5:0]
`define FN_ADD   6'h20
`define FN_ADDU  6'h21
`define FN_SUB   6'h22
`define FN_SUBU  6'h23

// first fetch address after reset
`define RESET_PC 32'h0000_3000

// data memory depth in words
`define DMEM_WORDS 1024

`endif

// ==== verilog/mipsPkg.sv ====
package mipsPkg;

    typedef logic [31:0] word_t;       // data word and byte address
    typedef logic [4:0]  regNum_t;     // gpr index
    typedef logic [15:0] imm16_t;      // raw i-type immediate
    typedef logic [1:0]  stageTime_t;  // tuse / tnew in pipeline stages

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,  // zero so a bubble decodes as add
        ALU_SUB = 2'd1,
        ALU_OR  = 2'd2,
        ALU_LUI = 2'd3
    } aluOp_t;

    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,  // keep the stage's own copy
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2
    } fwdSel_t;

    // decoded once in decode and carried down the pipe
    typedef struct packed {
        aluOp_t     aluOp;
        logic       useImm;    // alu operand b from immediate
        logic       zeroExt;   // ori zero-extends, others sign-extend
        logic       memWrite;
        logic       memToReg;  // result comes from data memory
        logic       regWrite;
        logic       isBeq;
        regNum_t    destReg;
        stageTime_t tuseRs;    // 3 means rs is not read
        stageTime_t tuseRt;
        stageTime_t tnew;      // counted from execute
    } ctrl_t;

    typedef struct packed {
        word_t   pc;
        regNum_t rsNum;
        regNum_t rtNum;
        word_t   rsVal;
        word_t   rtVal;
        word_t   extImm;
        ctrl_t   ctrl;
    } deStage_t;

    typedef struct packed {
        word_t   aluResult;  // also the data memory address
        word_t   storeData;
        regNum_t rtNum;
        ctrl_t   ctrl;
    } emStage_t;

    typedef struct packed {
        word_t aluResult;
        word_t loadData;
        ctrl_t ctrl;
    } mwStage_t;

    typedef struct packed {
        logic    valid;
        regNum_t regNum;
        word_t   data;
    } wbEvent_t;

endpackage

// ==== verilog/pcCounter.sv ====
`include "mipsDefines.svh"

module pcCounter (
    input  logic           clk,
    input  logic           arstN,
    input  logic           stall,         // decode cannot accept a new word
    input  logic           branchTaken,   // beq in decode resolved taken
    input  mipsPkg::word_t branchTarget,
    output mipsPkg::word_t pc
);

    mipsPkg::word_t pcNext;

    // redirect only ever lands after the delay slot, which is already in fetch
    always_comb begin
        if (branchTaken) begin
            pcNext = branchTarget;
        end else begin
            pcNext = pc + 32'd4;  // sequential word
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= `RESET_PC;
        end else if (!stall) begin
            pc <= pcNext;
        end
    end

endmodule

// ==== verilog/instrDecoder.sv ====
`include "mipsDefines.svh"

module instrDecoder (
    input  mipsPkg::word_t instr,
    output mipsPkg::ctrl_t ctrl,
    output mipsPkg::word_t extImm
);

    logic [5:0]       opcode;
    logic [5:0]       funct;
    mipsPkg::regNum_t rtNum;
    mipsPkg::regNum_t rdNum;
    mipsPkg::imm16_t  imm;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rtNum  = instr[20:16];
    assign rdNum  = instr[15:11];
    assign imm    = instr[15:0];

    always_comb begin
        ctrl = '0;  // unknown encodings fall through as a nop
        case (opcode)
            `OP_RTYPE: begin
                if (funct inside {`FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU}) begin
                    if (funct == `FN_SUB || funct == `FN_SUBU) begin
                        ctrl.aluOp = mipsPkg::ALU_SUB;  // no overflow trap either way
                    end
                    ctrl.regWrite = 1'b1;
                    ctrl.destReg  = rdNum;
                    ctrl.tuseRs   = 2'd1;
                    ctrl.tuseRt   = 2'd1;
                    ctrl.tnew     = 2'd1;
                end
            end
            `OP_ORI, `OP_LUI: begin
                ctrl.aluOp    = (opcode == `OP_ORI) ? mipsPkg::ALU_OR : mipsPkg::ALU_LUI;
                ctrl.useImm   = 1'b1;
                ctrl.zeroExt  = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.destReg  = rtNum;
                ctrl.tuseRs   = (opcode == `OP_ORI) ? 2'd1 : 2'd3;  // lui ignores rs
                ctrl.tuseRt   = 2'd3;
                ctrl.tnew     = 2'd1;
            end
            `OP_LW: begin
                ctrl.useImm   = 1'b1;  // base + offset
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.destReg  = rtNum;
                ctrl.tuseRs   = 2'd1;
                ctrl.tuseRt   = 2'd3;
                ctrl.tnew     = 2'd2;  // ready after memory
            end
            `OP_SW: begin
                ctrl.useImm   = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.tuseRs   = 2'd1;
                ctrl.tuseRt   = 2'd2;  // store data needed only in memory stage
            end
            `OP_BEQ: begin
                ctrl.isBeq  = 1'b1;
                ctrl.tuseRs = 2'd0;  // compared in decode
                ctrl.tuseRt = 2'd0;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    assign extImm = ctrl.zeroExt ? {16'h0000, imm} : {{16{imm[15]}}, imm};

endmodule

// ==== verilog/regFile.sv ====
module regFile (
    input  logic             clk,
    input  logic             arstN,
    input  mipsPkg::regNum_t rsNum,
    input  mipsPkg::regNum_t rtNum,
    output mipsPkg::word_t   rsData,
    output mipsPkg::word_t   rtData,
    input  logic             writeEn,
    input  mipsPkg::regNum_t writeNum,
    input  mipsPkg::word_t   writeData
);

    mipsPkg::word_t regs [32];
    logic           writeLive;  // a real write lands this cycle

    assign writeLive = writeEn && (writeNum != 5'd0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeLive) begin
            regs[writeNum] <= writeData;  // $0 never written so it stays zero
        end
    end

    // write-through covers the write-back to decode path
    assign rsData = (writeLive && writeNum == rsNum) ? writeData : regs[rsNum];
    assign rtData = (writeLive && writeNum == rtNum) ? writeData : regs[rtNum];

endmodule

// ==== verilog/hazardUnit.sv ====
module hazardUnit (
    input  mipsPkg::ctrl_t   decCtrl,
    input  mipsPkg::regNum_t decRs,
    input  mipsPkg::regNum_t decRt,
    input  mipsPkg::regNum_t exeRs,
    input  mipsPkg::regNum_t exeRt,
    input  mipsPkg::regNum_t memRt,
    input  mipsPkg::ctrl_t   exeCtrl,
    input  mipsPkg::ctrl_t   memCtrl,
    input  mipsPkg::regNum_t wbDest,
    input  logic             wbWrite,
    output logic             stall,
    output mipsPkg::fwdSel_t decFwdRs,
    output mipsPkg::fwdSel_t decFwdRt,
    output mipsPkg::fwdSel_t exeFwdRs,
    output mipsPkg::fwdSel_t exeFwdRt,
    output mipsPkg::fwdSel_t memFwdRt
);

    mipsPkg::stageTime_t exeRemain;
    mipsPkg::stageTime_t memRemain;
    logic                decActive;  // decode holds a real instruction
    logic                rsStall;
    logic                rtStall;
    logic                memReady;   // memory stage result already computed

    // true when the producer will not have its value by the time it is used
    function automatic logic late(input mipsPkg::regNum_t num, input mipsPkg::ctrl_t prod,
                                  input mipsPkg::stageTime_t remain,
                                  input mipsPkg::stageTime_t tuse);
        return (num != 5'd0) && prod.regWrite && (prod.destReg == num) && (remain > tuse);
    endfunction

    // memory beats write-back, $0 is never forwarded
    function automatic mipsPkg::fwdSel_t pick(input mipsPkg::regNum_t num, input logic memOk,
                                              input logic wbOk);
        mipsPkg::fwdSel_t sel;
        sel = mipsPkg::FWD_NONE;
        if (num != 5'd0) begin
            if (memOk && memCtrl.destReg == num) begin
                sel = mipsPkg::FWD_MEM;
            end else if (wbOk && wbWrite && wbDest == num) begin
                sel = mipsPkg::FWD_WB;
            end
        end
        return sel;
    endfunction

    assign exeRemain = exeCtrl.tnew;                                 // nothing passed yet
    assign memRemain = (memCtrl.tnew == 2'd0) ? 2'd0 : memCtrl.tnew - 2'd1;
    assign memReady  = memCtrl.regWrite && (memRemain == 2'd0);     // lw still in flight here

    assign decActive = decCtrl.regWrite || decCtrl.memWrite || decCtrl.isBeq;
    assign rsStall   = late(decRs, exeCtrl, exeRemain, decCtrl.tuseRs)
                    || late(decRs, memCtrl, memRemain, decCtrl.tuseRs);
    assign rtStall   = late(decRt, exeCtrl, exeRemain, decCtrl.tuseRt)
                    || late(decRt, memCtrl, memRemain, decCtrl.tuseRt);
    assign stall     = decActive && (rsStall || rtStall);

    assign decFwdRs = pick(decRs, memReady, 1'b0);  // regfile write-through covers wb
    assign decFwdRt = pick(decRt, memReady, 1'b0);
    assign exeFwdRs = pick(exeRs, memReady, 1'b1);
    assign exeFwdRt = pick(exeRt, memReady, 1'b1);
    assign memFwdRt = pick(memRt, 1'b0, 1'b1);      // store data, only wb is later

endmodule

// ==== verilog/execAlu.sv ====
module execAlu (
    input  mipsPkg::deStage_t stage,
    input  mipsPkg::word_t    srcA,    // forwarded rs
    input  mipsPkg::word_t    srcB,    // forwarded rt
    output mipsPkg::word_t    result
);

    mipsPkg::word_t opB;

    assign opB = stage.ctrl.useImm ? stage.extImm : srcB;

    always_comb begin
        case (stage.ctrl.aluOp)
            mipsPkg::ALU_ADD: begin
                result = srcA + opB;  // wraps, addresses for lw/sw too
            end
            mipsPkg::ALU_SUB: begin
                result = srcA - opB;
            end
            mipsPkg::ALU_OR: begin
                result = srcA | opB;
            end
            mipsPkg::ALU_LUI: begin
                result = {opB[15:0], 16'h0000};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== verilog/dataMem.sv ====
`include "mipsDefines.svh"

module dataMem (
    input  logic           clk,
    input  logic           arstN,
    input  mipsPkg::word_t addr,       // byte address, low bits dropped
    input  logic           writeEn,
    input  mipsPkg::word_t writeData,
    output mipsPkg::word_t readData
);

    localparam int AddrBits = $clog2(`DMEM_WORDS);

    mipsPkg::word_t         mem [`DMEM_WORDS];
    logic [AddrBits-1:0]    wordIdx;

    assign wordIdx = addr[AddrBits+1:2];  // upper address bits alias

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (writeEn) begin
            mem[wordIdx] <= writeData;
        end
    end

    assign readData = mem[wordIdx];

endmodule

// ==== verilog/mipsCore.sv ====
module mipsCore (
    input  logic              clk,
    input  logic              arstN,
    output mipsPkg::word_t    imemAddr,
    input  mipsPkg::word_t    imemData,
    output mipsPkg::wbEvent_t wbEvent
);

    mipsPkg::word_t    fdPc;      // fetch/decode register
    mipsPkg::word_t    fdInstr;
    mipsPkg::deStage_t deStage;
    mipsPkg::deStage_t deNext;
    mipsPkg::emStage_t emStage;
    mipsPkg::mwStage_t mwStage;

    mipsPkg::ctrl_t    decCtrl;
    mipsPkg::word_t    decImm;
    mipsPkg::regNum_t  decRs;
    mipsPkg::regNum_t  decRt;
    mipsPkg::imm16_t   brOffset;
    mipsPkg::word_t    rfRs;
    mipsPkg::word_t    rfRt;
    mipsPkg::word_t    decRsVal;
    mipsPkg::word_t    decRtVal;
    mipsPkg::word_t    branchTarget;
    logic              branchTaken;
    logic              stall;

    mipsPkg::fwdSel_t  decFwdRs;
    mipsPkg::fwdSel_t  decFwdRt;
    mipsPkg::fwdSel_t  exeFwdRs;
    mipsPkg::fwdSel_t  exeFwdRt;
    mipsPkg::fwdSel_t  memFwdRt;
    mipsPkg::word_t    exeA;
    mipsPkg::word_t    exeB;
    mipsPkg::word_t    aluResult;
    mipsPkg::word_t    storeData;
    mipsPkg::word_t    loadData;
    mipsPkg::word_t    wbData;

    function automatic mipsPkg::word_t fwdMux(input mipsPkg::fwdSel_t sel,
                                              input mipsPkg::word_t own,
                                              input mipsPkg::word_t memVal,
                                              input mipsPkg::word_t wbVal);
        case (sel)
            mipsPkg::FWD_MEM: return memVal;
            mipsPkg::FWD_WB:  return wbVal;
            default:          return own;
        endcase
    endfunction

    pcCounter i_pcCounter (
        .clk          (clk),
        .arstN        (arstN),
        .stall        (stall),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .pc           (imemAddr)
    );

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            fdPc    <= '0;
            fdInstr <= '0;  // nop
        end else if (!stall) begin
            fdPc    <= imemAddr;
            fdInstr <= imemData;
        end
    end

    // decode
    assign decRs    = fdInstr[25:21];
    assign decRt    = fdInstr[20:16];
    assign brOffset = fdInstr[15:0];

    instrDecoder i_instrDecoder (
        .instr  (fdInstr),
        .ctrl   (decCtrl),
        .extImm (decImm)
    );

    regFile i_regFile (
        .clk       (clk),
        .arstN     (arstN),
        .rsNum     (decRs),
        .rtNum     (decRt),
        .rsData    (rfRs),
        .rtData    (rfRt),
        .writeEn   (mwStage.ctrl.regWrite),
        .writeNum  (mwStage.ctrl.destReg),
        .writeData (wbData)
    );

    hazardUnit i_hazardUnit (
        .decCtrl  (decCtrl),
        .decRs    (decRs),
        .decRt    (decRt),
        .exeRs    (deStage.rsNum),
        .exeRt    (deStage.rtNum),
        .memRt    (emStage.rtNum),
        .exeCtrl  (deStage.ctrl),
        .memCtrl  (emStage.ctrl),
        .wbDest   (mwStage.ctrl.destReg),
        .wbWrite  (mwStage.ctrl.regWrite),
        .stall    (stall),
        .decFwdRs (decFwdRs),
        .decFwdRt (decFwdRt),
        .exeFwdRs (exeFwdRs),
        .exeFwdRt (exeFwdRt),
        .memFwdRt (memFwdRt)
    );

    assign decRsVal = fwdMux(decFwdRs, rfRs, emStage.aluResult, wbData);
    assign decRtVal = fwdMux(decFwdRt, rfRt, emStage.aluResult, wbData);

    // fetch pc is the delay slot while beq sits in decode
    assign branchTaken  = decCtrl.isBeq && (decRsVal == decRtVal) && !stall;
    assign branchTarget = imemAddr + 32'd4 + {{14{brOffset[15]}}, brOffset, 2'b00};

    always_comb begin
        deNext.pc     = fdPc;
        deNext.rsNum  = decRs;
        deNext.rtNum  = decRt;
        deNext.rsVal  = decRsVal;
        deNext.rtVal  = decRtVal;
        deNext.extImm = decImm;
        deNext.ctrl   = stall ? '0 : decCtrl;  // bubble while decode waits
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            deStage <= '0;
        end else begin
            deStage <= deNext;
        end
    end

    // execute
    assign exeA = fwdMux(exeFwdRs, deStage.rsVal, emStage.aluResult, wbData);
    assign exeB = fwdMux(exeFwdRt, deStage.rtVal, emStage.aluResult, wbData);

    execAlu i_execAlu (
        .stage  (deStage),
        .srcA   (exeA),
        .srcB   (exeB),
        .result (aluResult)
    );

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            emStage <= '0;
        end else begin
            emStage.aluResult <= aluResult;
            emStage.storeData <= exeB;  // may be refreshed from wb next cycle
            emStage.rtNum     <= deStage.rtNum;
            emStage.ctrl      <= deStage.ctrl;
        end
    end

    // memory
    assign storeData = fwdMux(memFwdRt, emStage.storeData, emStage.aluResult, wbData);

    dataMem i_dataMem (
        .clk       (clk),
        .arstN     (arstN),
        .addr      (emStage.aluResult),
        .writeEn   (emStage.ctrl.memWrite),
        .writeData (storeData),
        .readData  (loadData)
    );

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mwStage <= '0;
        end else begin
            mwStage.aluResult <= emStage.aluResult;
            mwStage.loadData  <= loadData;
            mwStage.ctrl      <= emStage.ctrl;
        end
    end

    // write-back
    assign wbData = mwStage.ctrl.memToReg ? mwStage.loadData : mwStage.aluResult;

    assign wbEvent.valid  = mwStage.ctrl.regWrite && (mwStage.ctrl.destReg != 5'd0);
    assign wbEvent.regNum = mwStage.ctrl.destReg;
    assign wbEvent.data   = wbData;

endmodule

// ==== tests/mipsCoreTb.sv ====
`include "mipsDefines.svh"

module mipsCoreTb;

    logic                clk;
    logic                arstN;
    mipsPkg::word_t      imemAddr;
    mipsPkg::word_t      imemData;
    mipsPkg::wbEvent_t   wbEvent;

    mipsPkg::word_t      progMem [64];           // instruction words, index = word offset
    int                  progLen;
    mipsPkg::word_t      pcOff;
    mipsPkg::word_t      model [32];             // architectural register state
    mipsPkg::word_t      modelMem [`DMEM_WORDS];
    mipsPkg::regNum_t    expReg [$];             // expected write-backs in order
    mipsPkg::word_t      expVal [$];
    int                  skipLeft;               // words still on the untaken side of a beq
    int                  armedSkip;              // takes effect after the delay slot
    int unsigned         lcgState;
    int                  errors;
    int                  checks;

    mipsCore i_mipsCore (
        .clk      (clk),
        .arstN    (arstN),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .wbEvent  (wbEvent)
    );

    // instruction memory, nop past the end of the program
    assign pcOff    = (imemAddr - `RESET_PC) >> 2;
    assign imemData = (pcOff < progLen) ? progMem[pcOff[5:0]] : 32'h0000_0000;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic mipsPkg::imm16_t lcgNext();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[30:15];  // upper bits, low ones cycle too fast
    endfunction

    function automatic mipsPkg::word_t encodeR(input mipsPkg::regNum_t rs, input mipsPkg::regNum_t rt,
                                               input mipsPkg::regNum_t rd, input logic [5:0] fn);
        return {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic mipsPkg::word_t encodeI(input logic [5:0] op, input mipsPkg::regNum_t rs,
                                               input mipsPkg::regNum_t rt, input mipsPkg::imm16_t imm);
        return {op, rs, rt, imm};
    endfunction

    // appends a word and its write-back, unless a taken beq skips it
    task automatic record(input mipsPkg::word_t instr, input logic writes,
                          input mipsPkg::regNum_t dst, input mipsPkg::word_t val);
        progMem[progLen] = instr;
        progLen++;
        if (skipLeft > 0) begin
            skipLeft--;
        end else begin
            if (writes && dst != 5'd0) begin  // $0 stays zero and is never reported
                model[dst] = val;
                expReg.push_back(dst);
                expVal.push_back(val);
            end
            skipLeft  = armedSkip;
            armedSkip = 0;
        end
    endtask

    task automatic arith(input logic [5:0] fn, input mipsPkg::regNum_t rd,
                         input mipsPkg::regNum_t rs, input mipsPkg::regNum_t rt);
        mipsPkg::word_t val;
        if (fn == `FN_SUB || fn == `FN_SUBU) begin
            val = model[rs] - model[rt];  // wraps, no trap
        end else begin
            val = model[rs] + model[rt];
        end
        record(encodeR(rs, rt, rd, fn), 1'b1, rd, val);
    endtask

    task automatic orImm(input mipsPkg::regNum_t rt, input mipsPkg::regNum_t rs,
                         input mipsPkg::imm16_t imm);
        record(encodeI(`OP_ORI, rs, rt, imm), 1'b1, rt, model[rs] | {16'h0000, imm});
    endtask

    task automatic loadUpper(input mipsPkg::regNum_t rt, input mipsPkg::imm16_t imm);
        record(encodeI(`OP_LUI, 5'd0, rt, imm), 1'b1, rt, {imm, 16'h0000});
    endtask

    task automatic storeWord(input mipsPkg::regNum_t rt, input mipsPkg::regNum_t rs,
                             input mipsPkg::imm16_t off);
        mipsPkg::word_t addr;
        addr = model[rs] + {{16{off[15]}}, off};
        if (skipLeft == 0) begin
            modelMem[(addr >> 2) % `DMEM_WORDS] = model[rt];
        end
        record(encodeI(`OP_SW, rs, rt, off), 1'b0, 5'd0, '0);
    endtask

    task automatic loadWord(input mipsPkg::regNum_t rt, input mipsPkg::regNum_t rs,
                            input mipsPkg::imm16_t off);
        mipsPkg::word_t addr;
        addr = model[rs] + {{16{off[15]}}, off};
        record(encodeI(`OP_LW, rs, rt, off), 1'b1, rt, modelMem[(addr >> 2) % `DMEM_WORDS]);
    endtask

    // off counts words skipped after the delay slot when taken
    task automatic branchEq(input mipsPkg::regNum_t rs, input mipsPkg::regNum_t rt, input int off);
        logic live;
        logic taken;
        live  = (skipLeft == 0);
        taken = (model[rs] == model[rt]);
        record(encodeI(`OP_BEQ, rs, rt, off[15:0]), 1'b0, 5'd0, '0);
        if (live && taken) begin
            armedSkip = off;
        end
    endtask

    task automatic buildProgram();
        lcgState  = 71;
        progLen   = 0;
        skipLeft  = 0;
        armedSkip = 0;
        for (int r = 0; r < 32; r++) begin
            model[r] = '0;
        end
        for (int a = 0; a < `DMEM_WORDS; a++) begin
            modelMem[a] = '0;
        end
        loadUpper(5'd1, lcgNext());
        orImm(5'd1, 5'd1, lcgNext());         // uses lui result at once
        orImm(5'd2, 5'd0, lcgNext());
        arith(`FN_ADDU, 5'd3, 5'd1, 5'd2);
        arith(`FN_SUBU, 5'd4, 5'd3, 5'd1);    // mem forward of $3
        arith(`FN_ADD, 5'd5, 5'd4, 5'd3);     // mem and wb forwards
        arith(`FN_SUB, 5'd5, 5'd5, 5'd2);
        orImm(5'd10, 5'd0, 16'h0040);          // data base address
        arith(`FN_ADD, 5'd6, 5'd5, 5'd1);
        storeWord(5'd6, 5'd10, 16'h0000);      // store data from the add just before
        loadWord(5'd7, 5'd10, 16'h0000);
        arith(`FN_ADDU, 5'd8, 5'd7, 5'd2);    // load-use, one stall
        storeWord(5'd8, 5'd10, 16'h0004);
        loadWord(5'd9, 5'd10, 16'h0004);
        arith(`FN_SUBU, 5'd11, 5'd9, 5'd7);
        orImm(5'd12, 5'd0, lcgNext());
        orImm(5'd13, 5'd12, 16'h0000);
        branchEq(5'd12, 5'd13, 2);             // needs $13 from execute, stalls
        orImm(5'd14, 5'd0, 16'h0011);          // delay slot
        orImm(5'd15, 5'd0, 16'h0022);
        orImm(5'd16, 5'd0, 16'h0033);
        arith(`FN_ADDU, 5'd17, 5'd14, 5'd12); // branch target
        branchEq(5'd12, 5'd2, 1);              // normally not taken
        arith(`FN_ADDU, 5'd18, 5'd17, 5'd1);
        arith(`FN_SUBU, 5'd19, 5'd18, 5'd2);
        orImm(5'd0, 5'd1, lcgNext());          // write to $0 is dropped
        arith(`FN_ADDU, 5'd20, 5'd0, 5'd2);
        loadUpper(5'd0, lcgNext());
        arith(`FN_SUBU, 5'd21, 5'd2, 5'd0);
        record(encodeI(6'h3f, 5'd1, 5'd20, 16'hbeef), 1'b0, 5'd0, '0);  // undefined opcode
        arith(`FN_ADDU, 5'd22, 5'd20, 5'd21);
        loadWord(5'd23, 5'd10, 16'h0000);
        branchEq(5'd23, 5'd6, 1);              // lw result compared in decode
        orImm(5'd24, 5'd23, 16'h0100);
        orImm(5'd25, 5'd0, 16'h0bad);
        arith(`FN_ADDU, 5'd26, 5'd24, 5'd23);
    endtask

    task automatic checkValue(input string what, input mipsPkg::word_t got,
                              input mipsPkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // one wait per call, so back to back events are seen one by one
    task automatic waitWriteBack(output logic seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < 50) begin
            @(negedge clk);
            seen = wbEvent.valid;
            cycles++;
        end
    endtask

    initial begin
        logic seen;
        logic timedOut;
        arstN    = 1'b0;
        errors   = 0;
        checks   = 0;
        timedOut = 1'b0;
        buildProgram();
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            checkValue("wbEvent.valid in reset", {31'd0, wbEvent.valid}, 32'd0);
            checkValue("imemAddr in reset", imemAddr, `RESET_PC);
        end
        @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);
        checkValue("first imemAddr", imemAddr, `RESET_PC);
        checkValue("wbEvent.valid after reset", {31'd0, wbEvent.valid}, 32'd0);
        for (int i = 0; i < expReg.size() && !timedOut; i++) begin
            waitWriteBack(seen);
            if (!seen) begin
                $display("timeout: no write-back seen for expected entry %0d", i);
                errors++;
                timedOut = 1'b1;
            end else begin
                checkValue($sformatf("regNum of entry %0d", i), {27'd0, wbEvent.regNum},
                           {27'd0, expReg[i]});
                checkValue($sformatf("data of entry %0d", i), wbEvent.data, expVal[i]);
            end
        end
        for (int c = 0; c < 20 && !timedOut; c++) begin
            @(negedge clk);  // program has drained, only nops follow
            if (wbEvent.valid) begin
                $display("unexpected write-back to register %0d after the program ended",
                         wbEvent.regNum);
                errors++;
            end
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== mipsCore.f ====
+incdir+verilog
verilog/mipsPkg.sv
verilog/pcCounter.sv
verilog/instrDecoder.sv
verilog/regFile.sv
verilog/hazardUnit.sv
verilog/execAlu.sv
verilog/dataMem.sv
verilog/mipsCore.sv
tests/mipsCoreTb.sv
